// File: sim/fetch_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top_tb;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_STEPS    = 28;
  localparam int WAIT_LIMIT   = 40;
  localparam int CYCLE_LIMIT  = NUM_STEPS * 60 + RESET_CYCLES;

  typedef enum logic [2:0] {
    STORE,
    LOAD,
    FETCH,
    JUMP_FETCH,
    LOAD_DURING_FETCH
  } step_kind_e;

  typedef struct packed {
    step_kind_e  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_val;
  } step_t;

  logic             clk;
  logic             rst_n;
  fetch_pkg::pc_t   pc_i;
  logic             jmp_flush_i;
  logic             inst_valid_o;
  fetch_pkg::inst_t inst_o;
  logic             dreq_valid_i;
  logic             dreq_ready_o;
  bus_pkg::bus_op_e dreq_op_i;
  fetch_pkg::pc_t   daddr_i;
  logic [31:0]      dwdata_i;
  logic             drsp_valid_o;
  logic             drsp_ready_i;
  logic [31:0]      drdata_o;

  step_t       steps [NUM_STEPS];
  // word view of the 64 line memory
  logic [31:0] model_mem [256];
  int          num_built;
  int          error_count;
  int          cycle_count;

  fetch_top #(
    .RESET_PC   (32'h0000_0000),
    .FIFO_DEPTH (4),
    .MEM_LINES  (64)
  ) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .jmp_flush_i  (jmp_flush_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .dreq_valid_i (dreq_valid_i),
    .dreq_ready_o (dreq_ready_o),
    .dreq_op_i    (dreq_op_i),
    .daddr_i      (daddr_i),
    .dwdata_i     (dwdata_i),
    .drsp_valid_o (drsp_valid_o),
    .drsp_ready_i (drsp_ready_i),
    .drdata_o     (drdata_o)
  );

  // ========================================
  // clock and watchdog
  // ========================================

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d", error_count + 1);
        $display("Errors found");
        $finish;
      end
    end
  end

  // ========================================
  // helpers
  // ========================================

  task automatic next_drive();
    @(posedge clk);
    #5;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    if (got !== exp_val) begin
      error_count++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp_val);
    end
  endtask

  // stores update the model so later steps know what to expect
  task automatic add_step(input step_kind_e kind, input logic [31:0] addr);
    step_t s;
    s.kind = kind;
    s.addr = addr;
    s.data = $urandom;
    if (kind == STORE) begin
      model_mem[addr[9:2]] = s.data;
    end
    s.exp_val = model_mem[addr[9:2]];
    steps[num_built] = s;
    num_built++;
  endtask

  // one data port request and its response
  task automatic data_access(input bus_pkg::bus_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic ok);
    int   waited;
    logic done;
    rdata        = '0;
    ok           = 1'b0;
    dreq_valid_i = 1'b1;
    dreq_op_i    = op;
    daddr_i      = addr;
    dwdata_i     = wdata;
    waited       = 0;
    done         = 1'b0;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      done = dreq_ready_o;
      waited++;
    end
    next_drive();
    dreq_valid_i = 1'b0;
    if (!done) begin
      error_count++;
      $display("data request to 0x%h was never accepted", addr);
    end else begin
      waited = 0;
      done   = 1'b0;
      while (!done && waited < WAIT_LIMIT) begin
        @(negedge clk);
        done = drsp_valid_o;
        waited++;
      end
      if (done) begin
        rdata = drdata_o;
        ok    = 1'b1;
      end else begin
        error_count++;
        $display("data response for 0x%h never arrived", addr);
      end
      next_drive();
    end
  endtask

  // checked at the first cycle the instruction is valid
  task automatic wait_inst(input logic [31:0] exp_val, input logic [31:0] addr);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      done = inst_valid_o;
      waited++;
    end
    if (done) begin
      check_value("inst_o", inst_o, exp_val);
    end else begin
      error_count++;
      $display("no valid instruction for pc 0x%h", addr);
    end
    next_drive();
  endtask

  // ========================================
  // stimulus
  // ========================================

  initial begin
    logic [31:0] rdata;
    logic        ok;
    rst_n        = 1'b1;
    pc_i         = 32'h0000_0000;
    jmp_flush_i  = 1'b0;
    dreq_valid_i = 1'b0;
    dreq_op_i    = bus_pkg::OP_READ_LINE;
    daddr_i      = '0;
    dwdata_i     = '0;
    drsp_ready_i = 1'b1;
    error_count  = 0;
    num_built    = 0;
    void'($urandom(32'he02b4f0e));

    // program words and a line with overwritten words
    add_step(STORE, 32'h000);
    add_step(STORE, 32'h008);
    add_step(STORE, 32'h010);
    add_step(STORE, 32'h018);
    add_step(STORE, 32'h020);
    add_step(STORE, 32'h028);
    add_step(STORE, 32'h030);
    add_step(STORE, 32'h104);
    add_step(STORE, 32'h108);
    add_step(STORE, 32'h10c);
    add_step(STORE, 32'h110);
    add_step(STORE, 32'h200);
    add_step(STORE, 32'h204);
    add_step(STORE, 32'h200);
    add_step(LOAD, 32'h200);
    add_step(LOAD, 32'h204);
    // the fifo still holds lines read before the stores
    add_step(JUMP_FETCH, 32'h000);
    add_step(FETCH, 32'h008);
    add_step(FETCH, 32'h010);
    add_step(FETCH, 32'h018);
    add_step(FETCH, 32'h020);
    add_step(FETCH, 32'h028);
    add_step(FETCH, 32'h030);
    add_step(JUMP_FETCH, 32'h104);
    add_step(LOAD_DURING_FETCH, 32'h018);
    add_step(FETCH, 32'h108);
    add_step(FETCH, 32'h10c);
    add_step(FETCH, 32'h110);

    for (int i = 0; i < RESET_CYCLES; i++) begin
      next_drive();
      check_value("inst_valid_o", inst_valid_o, 32'h0);
      check_value("drsp_valid_o", drsp_valid_o, 32'h0);
      check_value("dreq_ready_o", dreq_ready_o, 32'h0);
    end
    rst_n = 1'b0;

    for (int i = 0; i < num_built; i++) begin
      // prefetch is still refilling when the load goes out
      if (steps[i].kind != LOAD_DURING_FETCH) begin
        repeat ($urandom % 3) next_drive();
      end
      case (steps[i].kind)
        STORE: begin
          data_access(bus_pkg::OP_WRITE_WORD, steps[i].addr, steps[i].data, rdata, ok);
        end
        LOAD, LOAD_DURING_FETCH: begin
          data_access(bus_pkg::OP_READ_LINE, steps[i].addr, steps[i].data, rdata, ok);
          if (ok) begin
            check_value("drdata_o", rdata, steps[i].exp_val);
          end
        end
        FETCH: begin
          pc_i = steps[i].addr;
          wait_inst(steps[i].exp_val, steps[i].addr);
        end
        JUMP_FETCH: begin
          pc_i        = steps[i].addr;
          jmp_flush_i = 1'b1;
          next_drive();
          jmp_flush_i = 1'b0;
          wait_inst(steps[i].exp_val, steps[i].addr);
        end
        default: begin
          error_count++;
          $display("unknown step kind at step %0d", i);
        end
      endcase
    end

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // ========================================
  // memory bus encodings
  // ========================================

  typedef enum logic {
    OP_READ_LINE  = 1'b0,
    OP_WRITE_WORD = 1'b1
  } bus_op_e;

  // only OKAY is ever returned by line_mem
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00,
    RESP_ERR  = 2'b10
  } bus_resp_e;

  // ========================================
  // request and response payloads
  // ========================================

  typedef struct packed {
    bus_op_e              op;
    fetch_pkg::line_tag_t addr;
    logic [1:0]           word;
    logic [31:0]          wdata;
    // one bit per word of the line
    logic [3:0]           wstrb;
  } bus_req_t;

  typedef struct packed {
    fetch_pkg::line_t data;
    bus_resp_e        resp;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,
    ARB_MEM_REQ = 2'd1,
    ARB_MEM_RSP = 2'd2
  } arb_state_e;

endpackage

`default_nettype wire

// File: src/data_port.sv
`timescale 1ns/1ns
`default_nettype none

module data_port (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dreq_valid_i,
  output logic              dreq_ready_o,
  input  bus_pkg::bus_op_e  dreq_op_i,
  input  fetch_pkg::pc_t    daddr_i,
  input  logic [31:0]       dwdata_i,
  output logic              drsp_valid_o,
  input  logic              drsp_ready_i,
  output logic [31:0]       drdata_o,
  output logic              req_valid_o,
  input  logic              req_ready_i,
  output bus_pkg::bus_req_t req_o,
  input  logic              rsp_valid_i,
  output logic              rsp_ready_o,
  input  bus_pkg::bus_rsp_t rsp_i
);

  // init keeps dreq_ready_o low through reset
  typedef enum logic [2:0] {
    DP_INIT = 3'd0,
    DP_IDLE = 3'd1,
    DP_REQ  = 3'd2,
    DP_RSP  = 3'd3,
    DP_DONE = 3'd4
  } dp_state_e;

  dp_state_e        state_q;
  bus_pkg::bus_op_e op_q;
  fetch_pkg::pc_t   addr_q;
  logic [31:0]      wdata_q;
  logic [31:0]      rdata_q;
  logic [1:0]       word_idx;
  logic             dreq_fire;
  logic             rsp_fire;

  assign word_idx  = addr_q[3:2];
  assign dreq_fire = dreq_valid_i & dreq_ready_o;
  assign rsp_fire  = rsp_valid_i & rsp_ready_o;

  assign dreq_ready_o = (state_q == DP_IDLE);
  assign req_valid_o  = (state_q == DP_REQ);
  assign rsp_ready_o  = (state_q == DP_RSP);
  assign drsp_valid_o = (state_q == DP_DONE);
  assign drdata_o     = rdata_q;

  always_comb begin
    req_o       = '0;
    req_o.op    = op_q;
    req_o.addr  = addr_q[31:4];
    req_o.word  = word_idx;
    req_o.wdata = wdata_q;
    // one-hot word strobe for stores only
    if (op_q == bus_pkg::OP_WRITE_WORD) begin
      req_o.wstrb = 4'b0001 << word_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= DP_INIT;
    end else begin
      case (state_q)
        DP_INIT: state_q <= DP_IDLE;
        DP_IDLE: if (dreq_fire) state_q <= DP_REQ;
        DP_REQ:  if (req_valid_o && req_ready_i) state_q <= DP_RSP;
        DP_RSP:  if (rsp_fire) state_q <= DP_DONE;
        DP_DONE: if (drsp_ready_i) state_q <= DP_IDLE;
        default: state_q <= DP_INIT;
      endcase
    end
  end

  // request capture and load word select
  always_ff @(posedge clk) begin
    if (dreq_fire) begin
      op_q    <= dreq_op_i;
      addr_q  <= daddr_i;
      wdata_q <= dwdata_i;
    end
    if (rsp_fire && op_q == bus_pkg::OP_READ_LINE) begin
      rdata_q <= rsp_i.data[{word_idx, 5'b0} +: 32];
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer #(
  parameter fetch_pkg::pc_t RESET_PC   = 32'h0000_0000,
  parameter int             FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  fetch_pkg::pc_t    pc_i,
  input  logic              jmp_flush_i,
  output logic              inst_valid_o,
  output fetch_pkg::inst_t  inst_o,
  output logic              req_valid_o,
  input  logic              req_ready_i,
  output bus_pkg::bus_req_t req_o,
  input  logic              rsp_valid_i,
  output logic              rsp_ready_o,
  input  bus_pkg::bus_rsp_t rsp_i
);

  typedef enum logic {
    FB_IDLE = 1'b0,
    FB_WAIT = 1'b1
  } fb_state_e;

  fb_state_e              state_q;
  fetch_pkg::line_tag_t   pc_tag;
  fetch_pkg::line_tag_t   pf_tag_q;
  fetch_pkg::line_tag_t   req_tag_q;
  logic                   discard_q;
  logic                   req_fire;
  logic                   rsp_fire;
  logic                   fifo_push;
  logic                   fifo_pop;
  logic                   fifo_empty;
  logic                   fifo_full;
  logic                   head_valid;
  fetch_pkg::line_entry_t push_entry;
  fetch_pkg::line_entry_t head;

  assign pc_tag   = pc_i[31:4];
  assign req_fire = req_valid_o & req_ready_i;
  assign rsp_fire = rsp_valid_i & rsp_ready_o;

  // ========================================
  // prefetch requests
  // ========================================

  // one line read in flight at most
  assign req_valid_o = (state_q == FB_IDLE) & ~fifo_full;
  assign rsp_ready_o = (state_q == FB_WAIT);

  always_comb begin
    req_o      = '0;
    req_o.op   = bus_pkg::OP_READ_LINE;
    req_o.addr = pf_tag_q;
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= FB_IDLE;
    end else begin
      case (state_q)
        FB_IDLE: begin
          if (req_fire) begin
            state_q <= FB_WAIT;
          end
        end
        FB_WAIT: begin
          if (rsp_fire) begin
            state_q <= FB_IDLE;
          end
        end
        default: state_q <= FB_IDLE;
      endcase
    end
  end

  // next line to ask for unless a jump redirects it
  always_ff @(posedge clk) begin
    if (rst_n) begin
      pf_tag_q <= RESET_PC[31:4];
    end else if (jmp_flush_i) begin
      pf_tag_q <= pc_tag;
    end else if (req_fire) begin
      pf_tag_q <= pf_tag_q + 1'b1;
    end
  end

  // tag of the line currently in flight
  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_tag_q <= pf_tag_q;
    end
  end

  // marks a read in flight that a jump made stale
  always_ff @(posedge clk) begin
    if (rst_n) begin
      discard_q <= 1'b0;
    end else if (jmp_flush_i && ((state_q == FB_WAIT && !rsp_fire) || req_fire)) begin
      discard_q <= 1'b1;
    end else if (rsp_fire) begin
      discard_q <= 1'b0;
    end
  end

  // ========================================
  // line FIFO and instruction select
  // ========================================

  assign fifo_push  = rsp_fire & ~discard_q & ~jmp_flush_i;
  assign push_entry = '{tag: req_tag_q, line: rsp_i.data};

  // drop lines the pc has moved past
  assign fifo_pop = ~fifo_empty & (head.tag != pc_tag);

  line_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_line_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (jmp_flush_i),
    .push_i      (fifo_push),
    .push_data_i (push_entry),
    .pop_i       (fifo_pop),
    .head_o      (head),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full)
  );

  // head is usable from the bypass too
  assign head_valid   = ~fifo_empty | fifo_push;
  assign inst_valid_o = head_valid & (head.tag == pc_tag);
  assign inst_o       = head.line[{pc_i[3:2], 5'b0} +: 32];

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ========================================
  // address and data widths
  // ========================================

  // byte address
  typedef logic [31:0] pc_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // four words with word 0 in the low bits
  typedef logic [127:0] line_t;

  // pc[31:4] that names one line
  typedef logic [27:0] line_tag_t;

  // ========================================
  // fetch side storage
  // ========================================

  // one prefetched line with the tag it was read from
  typedef struct packed {
    line_tag_t tag;
    line_t     line;
  } line_entry_t;

endpackage

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
  parameter fetch_pkg::pc_t RESET_PC   = 32'h0000_0000,
  parameter int             FIFO_DEPTH = 4,
  parameter int             MEM_LINES  = 64
) (
  input  logic             clk,
  input  logic             rst_n,
  // core fetch side
  input  fetch_pkg::pc_t   pc_i,
  input  logic             jmp_flush_i,
  output logic             inst_valid_o,
  output fetch_pkg::inst_t inst_o,
  // core data side
  input  logic             dreq_valid_i,
  output logic             dreq_ready_o,
  input  bus_pkg::bus_op_e dreq_op_i,
  input  fetch_pkg::pc_t   daddr_i,
  input  logic [31:0]      dwdata_i,
  output logic             drsp_valid_o,
  input  logic             drsp_ready_i,
  output logic [31:0]      drdata_o
);

  logic              f_req_valid;
  logic              f_req_ready;
  bus_pkg::bus_req_t f_req;
  logic              f_rsp_valid;
  logic              f_rsp_ready;
  bus_pkg::bus_rsp_t f_rsp;
  logic              d_req_valid;
  logic              d_req_ready;
  bus_pkg::bus_req_t d_req;
  logic              d_rsp_valid;
  logic              d_rsp_ready;
  bus_pkg::bus_rsp_t d_rsp;
  logic              m_req_valid;
  logic              m_req_ready;
  bus_pkg::bus_req_t m_req;
  logic              m_rsp_valid;
  logic              m_rsp_ready;
  bus_pkg::bus_rsp_t m_rsp;

  fetch_buffer #(
    .RESET_PC   (RESET_PC),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .jmp_flush_i  (jmp_flush_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .req_valid_o  (f_req_valid),
    .req_ready_i  (f_req_ready),
    .req_o        (f_req),
    .rsp_valid_i  (f_rsp_valid),
    .rsp_ready_o  (f_rsp_ready),
    .rsp_i        (f_rsp)
  );

  data_port u_data_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .dreq_valid_i (dreq_valid_i),
    .dreq_ready_o (dreq_ready_o),
    .dreq_op_i    (dreq_op_i),
    .daddr_i      (daddr_i),
    .dwdata_i     (dwdata_i),
    .drsp_valid_o (drsp_valid_o),
    .drsp_ready_i (drsp_ready_i),
    .drdata_o     (drdata_o),
    .req_valid_o  (d_req_valid),
    .req_ready_i  (d_req_ready),
    .req_o        (d_req),
    .rsp_valid_i  (d_rsp_valid),
    .rsp_ready_o  (d_rsp_ready),
    .rsp_i        (d_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .f_req_valid_i (f_req_valid),
    .f_req_ready_o (f_req_ready),
    .f_req_i       (f_req),
    .f_rsp_valid_o (f_rsp_valid),
    .f_rsp_ready_i (f_rsp_ready),
    .f_rsp_o       (f_rsp),
    .d_req_valid_i (d_req_valid),
    .d_req_ready_o (d_req_ready),
    .d_req_i       (d_req),
    .d_rsp_valid_o (d_rsp_valid),
    .d_rsp_ready_i (d_rsp_ready),
    .d_rsp_o       (d_rsp),
    .m_req_valid_o (m_req_valid),
    .m_req_ready_i (m_req_ready),
    .m_req_o       (m_req),
    .m_rsp_valid_i (m_rsp_valid),
    .m_rsp_ready_o (m_rsp_ready),
    .m_rsp_i       (m_rsp)
  );

  line_mem #(
    .MEM_LINES (MEM_LINES)
  ) u_line_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (m_req_valid),
    .req_ready_o (m_req_ready),
    .req_i       (m_req),
    .rsp_valid_o (m_rsp_valid),
    .rsp_ready_i (m_rsp_ready),
    .rsp_o       (m_rsp)
  );

endmodule

`default_nettype wire

// File: src/line_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module line_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   push_i,
  input  fetch_pkg::line_entry_t push_data_i,
  input  logic                   pop_i,
  output fetch_pkg::line_entry_t head_o,
  output logic                   empty_o,
  output logic                   full_o
);

  localparam int AW = $clog2(DEPTH);

  fetch_pkg::line_entry_t entries_q [DEPTH];

  // extra msb is the wrap bit
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic        do_push;
  logic        do_pop;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      entries_q[wr_ptr_q[AW-1:0]] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // bypass so a line lands at the head in the cycle it arrives
  assign head_o = (empty_o && push_i) ? push_data_i : entries_q[rd_ptr_q[AW-1:0]];

endmodule

`default_nettype wire

// File: src/line_mem.sv
`timescale 1ns/1ns
`default_nettype none

module line_mem #(
  parameter int MEM_LINES = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  bus_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output bus_pkg::bus_rsp_t rsp_o
);

  localparam int AW = $clog2(MEM_LINES);

  fetch_pkg::line_t  ram_q [MEM_LINES];
  bus_pkg::bus_rsp_t rsp_q;
  logic              rsp_valid_q;
  logic [AW-1:0]     idx;
  logic              req_fire;

  // low tag bits pick the line
  assign idx      = req_i.addr[AW-1:0];
  assign req_fire = req_valid_i & req_ready_o;

  // no new request while a response waits
  assign req_ready_o = ~rsp_valid_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // ========================================
  // storage
  // ========================================

  always_ff @(posedge clk) begin
    if (req_fire && req_i.op == bus_pkg::OP_WRITE_WORD) begin
      for (int w = 0; w < 4; w++) begin
        if (req_i.wstrb[w]) begin
          ram_q[idx][w*32 +: 32] <= req_i.wdata;
        end
      end
    end
  end

  // read data is the line before any write this cycle
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_q.data <= ram_q[idx];
      rsp_q.resp <= bus_pkg::RESP_OKAY;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  logic              clk,
  input  logic              rst_n,
  // fetch buffer side
  input  logic              f_req_valid_i,
  output logic              f_req_ready_o,
  input  bus_pkg::bus_req_t f_req_i,
  output logic              f_rsp_valid_o,
  input  logic              f_rsp_ready_i,
  output bus_pkg::bus_rsp_t f_rsp_o,
  // data port side
  input  logic              d_req_valid_i,
  output logic              d_req_ready_o,
  input  bus_pkg::bus_req_t d_req_i,
  output logic              d_rsp_valid_o,
  input  logic              d_rsp_ready_i,
  output bus_pkg::bus_rsp_t d_rsp_o,
  // memory side
  output logic              m_req_valid_o,
  input  logic              m_req_ready_i,
  output bus_pkg::bus_req_t m_req_o,
  input  logic              m_rsp_valid_i,
  output logic              m_rsp_ready_o,
  input  bus_pkg::bus_rsp_t m_rsp_i
);

  bus_pkg::arb_state_e state_q;
  // 1 means the data port
  logic                owner_q;
  logic                last_q;
  logic                grant_d;
  logic                in_req;
  logic                in_rsp;

  assign in_req = (state_q == bus_pkg::ARB_MEM_REQ);
  assign in_rsp = (state_q == bus_pkg::ARB_MEM_RSP);

  // tie goes to whoever lost last time
  always_comb begin
    if (f_req_valid_i && d_req_valid_i) begin
      grant_d = ~last_q;
    end else begin
      grant_d = d_req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= bus_pkg::ARB_IDLE;
      owner_q <= 1'b0;
      last_q  <= 1'b1;
    end else begin
      case (state_q)
        bus_pkg::ARB_IDLE: begin
          if (f_req_valid_i || d_req_valid_i) begin
            owner_q <= grant_d;
            last_q  <= grant_d;
            state_q <= bus_pkg::ARB_MEM_REQ;
          end
        end
        bus_pkg::ARB_MEM_REQ: begin
          if (m_req_valid_o && m_req_ready_i) begin
            state_q <= bus_pkg::ARB_MEM_RSP;
          end
        end
        bus_pkg::ARB_MEM_RSP: begin
          if (m_rsp_valid_i && m_rsp_ready_o) begin
            state_q <= bus_pkg::ARB_IDLE;
          end
        end
        default: state_q <= bus_pkg::ARB_IDLE;
      endcase
    end
  end

  // owner request through to memory
  assign m_req_valid_o = in_req & (owner_q ? d_req_valid_i : f_req_valid_i);
  assign m_req_o       = owner_q ? d_req_i : f_req_i;
  assign f_req_ready_o = in_req & ~owner_q & m_req_ready_i;
  assign d_req_ready_o = in_req & owner_q & m_req_ready_i;

  // response back to the owner only
  assign f_rsp_valid_o = in_rsp & ~owner_q & m_rsp_valid_i;
  assign d_rsp_valid_o = in_rsp & owner_q & m_rsp_valid_i;
  assign m_rsp_ready_o = in_rsp & (owner_q ? d_rsp_ready_i : f_rsp_ready_i);
  assign f_rsp_o       = m_rsp_i;
  assign d_rsp_o       = m_rsp_i;

endmodule

`default_nettype wire

// File: verilog.f
src/fetch_pkg.sv
src/bus_pkg.sv
src/line_fifo.sv
src/fetch_buffer.sv
src/data_port.sv
src/mem_arbiter.sv
src/line_mem.sv
src/fetch_top.sv
sim/fetch_top_tb.sv
